//--- verilog/conv_row_macros.svh
`ifndef CONV_ROW_MACROS_SVH
`define CONV_ROW_MACROS_SVH

// one register line holds one word of pixels
`define CONV_LINE_PIXELS 32

// column / register index and small geometry field widths
`define CONV_IDX_W 16
`define CONV_PARAM_W 4

// wishbone configuration port
`define CONV_WB_ADR_W 3
`define CONV_WB_DAT_W 32

// register map, word offsets
`define CONV_REG_CTRL 0
`define CONV_REG_IX 1
`define CONV_REG_POX 2
`define CONV_REG_KSP 3
`define CONV_REG_STATUS 4

// KSP register packing
`define CONV_KSP_K_LSB 0
`define CONV_KSP_S_LSB 4
`define CONV_KSP_P_LSB 8

`endif

//--- verilog/conv_row_pkg.sv
`include "conv_row_macros.svh"

package conv_row_pkg;

   typedef logic [`CONV_IDX_W-1:0] idx_t;
   typedef logic [`CONV_PARAM_W-1:0] param_t;

   // wishbone register offsets
   typedef enum logic [`CONV_WB_ADR_W-1:0] {
      REG_CTRL   = `CONV_REG_CTRL,
      REG_IX     = `CONV_REG_IX,
      REG_POX    = `CONV_REG_POX,
      REG_KSP    = `CONV_REG_KSP,
      REG_STATUS = `CONV_REG_STATUS
   } cfg_addr_e;

   typedef enum logic [1:0] {
      SEQ_IDLE,
      SEQ_ISSUE,
      SEQ_WAIT_TILE,
      SEQ_DONE
   } seq_state_e;

   typedef enum logic [1:0] {
      SEG_IDLE,
      SEG_PRIMARY,
      SEG_TAIL
   } seg_state_e;

   // one row segment as handed to the loader
   typedef struct packed {
      idx_t   col_start;
      idx_t   col_end;
      idx_t   reg_start;
      idx_t   reg_end;
      param_t west_pad;
      param_t east_pad;
   } row_segment_t;

endpackage

//--- verilog/conv_geom_if.sv
interface conv_geom_if
   import conv_row_pkg::*;
();

   // layer geometry, static while a layer runs
   idx_t   ix;
   idx_t   pox;
   param_t k;
   param_t s;
   param_t p;

   // one-cycle kick and end-of-layer report
   logic   start_pulse;
   logic   layer_done;

   modport cfg (
      output ix, pox, k, s, p,
      output start_pulse,
      input  layer_done
   );

   modport user (
      input ix, pox, k, s, p,
      input start_pulse
   );

endinterface

//--- verilog/conv_cfg_regs.sv
`include "conv_row_macros.svh"

module conv_cfg_regs
   import conv_row_pkg::*;
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      wb_cyc,
   input  logic                      wb_stb,
   input  logic                      wb_we,
   input  logic [`CONV_WB_ADR_W-1:0] wb_adr,
   input  logic [`CONV_WB_DAT_W-1:0] wb_dat_w,
   output logic [`CONV_WB_DAT_W-1:0] wb_dat_r,
   output logic                      wb_ack,
   conv_geom_if.cfg                  geom
);

   cfg_addr_e                  addr;
   logic                       access;
   logic [`CONV_WB_DAT_W-1:0]  rd_data;

   idx_t   ix_q;
   idx_t   pox_q;
   param_t k_q;
   param_t s_q;
   param_t p_q;
   logic   start_q;
   logic   busy;
   logic   done;

   // new access only on the first cycle, ack drops the cycle after
   assign access = wb_cyc && wb_stb && !wb_ack;
   assign addr   = cfg_addr_e'(wb_adr);

   always_comb begin
      rd_data = '0;
      case (addr)
         REG_IX:     rd_data[`CONV_IDX_W-1:0] = ix_q;
         REG_POX:    rd_data[`CONV_IDX_W-1:0] = pox_q;
         REG_KSP: begin
            rd_data[`CONV_KSP_K_LSB +: `CONV_PARAM_W] = k_q;
            rd_data[`CONV_KSP_S_LSB +: `CONV_PARAM_W] = s_q;
            rd_data[`CONV_KSP_P_LSB +: `CONV_PARAM_W] = p_q;
         end
         REG_STATUS: rd_data[1:0] = {done, busy};
         // start bit is self clearing
         default:    rd_data = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_ack   <= 1'b0;
         wb_dat_r <= '0;
         start_q  <= 1'b0;
         busy     <= 1'b0;
         done     <= 1'b0;
         ix_q     <= '0;
         pox_q    <= '0;
         k_q      <= '0;
         s_q      <= '0;
         p_q      <= '0;
      end else begin
         wb_ack  <= access;
         start_q <= 1'b0;

         if (geom.layer_done) begin
            busy <= 1'b0;
            done <= 1'b1;
         end

         if (access && !wb_we) begin
            wb_dat_r <= rd_data;
         end

         if (access && wb_we) begin
            case (addr)
               REG_CTRL: begin
                  // ignored while a layer is running
                  if (wb_dat_w[0] && !busy) begin
                     start_q <= 1'b1;
                     busy    <= 1'b1;
                     done    <= 1'b0;
                  end
               end
               REG_IX:  ix_q  <= wb_dat_w[`CONV_IDX_W-1:0];
               REG_POX: pox_q <= wb_dat_w[`CONV_IDX_W-1:0];
               REG_KSP: begin
                  k_q <= wb_dat_w[`CONV_KSP_K_LSB +: `CONV_PARAM_W];
                  s_q <= wb_dat_w[`CONV_KSP_S_LSB +: `CONV_PARAM_W];
                  p_q <= wb_dat_w[`CONV_KSP_P_LSB +: `CONV_PARAM_W];
               end
               default: ;
            endcase
         end
      end
   end

   assign geom.ix          = ix_q;
   assign geom.pox         = pox_q;
   assign geom.k           = k_q;
   assign geom.s           = s_q;
   assign geom.p           = p_q;
   assign geom.start_pulse = start_q;

endmodule

//--- verilog/conv_tile_sequencer.sv
module conv_tile_sequencer
   import conv_row_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   conv_geom_if.user  geom,
   input  logic       tile_end,
   output logic       tile_go,
   output idx_t       ox_start,
   output logic       layer_done
);

   seq_state_e state;
   idx_t       ox_q;
   idx_t       out_num;
   idx_t       ox_calc;
   idx_t       next_ox;

   ////////////////////////////////////////////////////////////////////////////
   // output width, ox = (ix + 2p - k) / s + 1, stride 1 or 2 only
   ////////////////////////////////////////////////////////////////////////////
   assign out_num = geom.ix + (idx_t'(geom.p) << 1) - idx_t'(geom.k);
   assign ox_calc = ((geom.s == param_t'(2)) ? (out_num >> 1) : out_num) + 1'b1;

   // first column of the following tile
   assign next_ox = ox_start + geom.pox;

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= SEQ_IDLE;
         ox_q     <= '0;
         ox_start <= '0;
      end else begin
         case (state)
            SEQ_IDLE: begin
               if (geom.start_pulse) begin
                  ox_q     <= ox_calc;
                  ox_start <= idx_t'(1);
                  state    <= SEQ_ISSUE;
               end
            end
            SEQ_ISSUE: state <= SEQ_WAIT_TILE;
            SEQ_WAIT_TILE: begin
               if (tile_end) begin
                  // past the row end means the layer is finished
                  if (next_ox > ox_q) begin
                     state <= SEQ_DONE;
                  end else begin
                     ox_start <= next_ox;
                     state    <= SEQ_ISSUE;
                  end
               end
            end
            SEQ_DONE: state <= SEQ_IDLE;
            default:  state <= SEQ_IDLE;
         endcase
      end
   end

   assign tile_go    = (state == SEQ_ISSUE);
   assign layer_done = (state == SEQ_DONE);

endmodule

//--- verilog/conv_row_segment_gen.sv
`include "conv_row_macros.svh"

module conv_row_segment_gen
   import conv_row_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   conv_geom_if.user     geom,
   input  logic          tile_go,
   input  idx_t          ox_start,
   input  logic          seg_taken,
   output logic          seg_load,
   output row_segment_t  seg,
   output logic          tile_end
);

   seg_state_e state;
   idx_t       ox_q;
   idx_t       cur_col;
   idx_t       cur_reg;
   logic       first_q;
   logic       pending;
   logic       final_q;

   // tile geometry, padded 1-based columns
   idx_t       p_w;
   idx_t       ox_m1;
   idx_t       span;
   idx_t       ix_start;
   idx_t       ix_end;
   idx_t       ix_end_min0;
   idx_t       ix_end_min;
   idx_t       p_plus_ix;
   param_t     west_pad;
   param_t     east_pad;

   // unpadded 0-based column range
   idx_t       first_col;
   idx_t       last_min;
   idx_t       last_full;
   logic       has_tail;

   // current segment
   idx_t       col_start;
   idx_t       col_step_end;
   idx_t       col_end;
   idx_t       phase_last;
   idx_t       reg_start;
   idx_t       reg_body_end;
   logic       phase_final;
   logic       tile_final;

   // last column of a phase, padded end column mapped to the image,
   // rounded up to a line boundary and kept inside the row
   function automatic idx_t seg_last_col(idx_t end_col, idx_t pad, idx_t width);
      idx_t unp;
      idx_t rounded;
      if (end_col > pad + width) begin
         unp = width - 1'b1;
      end else if (end_col > pad + 1'b1) begin
         unp = end_col - pad - 1'b1;
      end else begin
         unp = '0;
      end
      rounded = unp | idx_t'(`CONV_LINE_PIXELS - 1);
      return (rounded > width - 1'b1) ? width - 1'b1 : rounded;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // column range of the tile
   ////////////////////////////////////////////////////////////////////////////
   assign p_w   = idx_t'(geom.p);
   assign ox_m1 = ox_q - 1'b1;

   // stride 2 doubles the step between output columns
   assign ix_start    = ((geom.s == param_t'(2)) ? (ox_m1 << 1) : ox_m1) + 1'b1;
   assign span        = (geom.s == param_t'(2)) ? ((geom.pox - 1'b1) << 1)
                                                : (geom.pox - 1'b1);
   assign ix_end      = ix_start + span + idx_t'(geom.k) - 1'b1;
   assign ix_end_min0 = ix_start + span + 1'b1;
   assign ix_end_min  = (ix_end_min0 > ix_end) ? ix_end : ix_end_min0;

   assign p_plus_ix = p_w + geom.ix;
   assign west_pad  = (ix_start <= p_w) ? param_t'(p_w - ix_start + 1'b1) : '0;
   assign east_pad  = (ix_end > p_plus_ix) ? param_t'(ix_end - p_plus_ix) : '0;

   assign first_col = (ix_start > p_w + 1'b1) ? (ix_start - p_w - 1'b1) : '0;
   assign last_min  = seg_last_col(ix_end_min, p_w, geom.ix);
   assign last_full = seg_last_col(ix_end, p_w, geom.ix);
   assign has_tail  = (last_full > last_min);

   ////////////////////////////////////////////////////////////////////////////
   // segment under construction
   ////////////////////////////////////////////////////////////////////////////
   assign col_start    = first_q ? first_col : cur_col;
   assign phase_last   = (state == SEG_TAIL) ? last_full : last_min;
   assign col_step_end = col_start + idx_t'(`CONV_LINE_PIXELS - 1);
   assign col_end      = (col_step_end < phase_last) ? col_step_end : phase_last;
   assign phase_final  = (col_end == phase_last);
   assign tile_final   = phase_final && ((state == SEG_TAIL) || !has_tail);

   // register indices skip the west pad slots on the first segment
   assign reg_start    = first_q ? (idx_t'(west_pad) + 1'b1) : cur_reg;
   assign reg_body_end = reg_start + (col_end - col_start);

   assign seg.col_start = col_start;
   assign seg.col_end   = col_end;
   assign seg.reg_start = reg_start;
   assign seg.reg_end   = reg_body_end + (tile_final ? idx_t'(east_pad) : '0);
   assign seg.west_pad  = first_q ? west_pad : '0;
   assign seg.east_pad  = tile_final ? east_pad : '0;

   // one segment in the issuer at a time
   assign seg_load = (state != SEG_IDLE) && !pending;
   assign tile_end = seg_taken && pending && final_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= SEG_IDLE;
         first_q <= 1'b0;
         pending <= 1'b0;
         final_q <= 1'b0;
      end else begin
         if (seg_taken) begin
            pending <= 1'b0;
         end
         case (state)
            SEG_IDLE: begin
               if (tile_go) begin
                  state   <= SEG_PRIMARY;
                  first_q <= 1'b1;
               end
            end
            SEG_PRIMARY, SEG_TAIL: begin
               if (seg_load) begin
                  pending <= 1'b1;
                  first_q <= 1'b0;
                  final_q <= tile_final;
                  if (tile_final) begin
                     state <= SEG_IDLE;
                  end else if (phase_final) begin
                     state <= SEG_TAIL;
                  end
               end
            end
            default: state <= SEG_IDLE;
         endcase
      end
   end

   // walk position, tail picks up right after the primary end
   always_ff @(posedge clk) begin
      if (tile_go && (state == SEG_IDLE)) begin
         ox_q <= ox_start;
      end
      if (seg_load) begin
         cur_col <= col_end + 1'b1;
         cur_reg <= reg_body_end + 1'b1;
      end
   end

endmodule

//--- verilog/conv_segment_issuer.sv
module conv_segment_issuer
   import conv_row_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          seg_load,
   input  row_segment_t  seg,
   input  logic          seg_ready,
   output logic          seg_valid,
   output row_segment_t  seg_out,
   output logic          seg_taken
);

   logic can_load;

   ////////////////////////////////////////////////////////////////////////////
   // one-entry holding register
   ////////////////////////////////////////////////////////////////////////////

   // transfer on valid and ready together
   assign seg_taken = seg_valid && seg_ready;

   // free slot, or the held entry leaves this cycle
   assign can_load = !seg_valid || seg_taken;

   always_ff @(posedge clk) begin
      if (reset) begin
         seg_valid <= 1'b0;
      end else if (seg_load && can_load) begin
         seg_valid <= 1'b1;
      end else if (seg_taken) begin
         seg_valid <= 1'b0;
      end
   end

   // fields frozen while stalled
   always_ff @(posedge clk) begin
      if (seg_load && can_load) begin
         seg_out <= seg;
      end
   end

endmodule

//--- verilog/conv_row_fetch_top.sv
`include "conv_row_macros.svh"

module conv_row_fetch_top
   import conv_row_pkg::*;
(
   input  logic                      clk,
   input  logic                      reset,

   // wishbone configuration port
   input  logic                      wb_cyc,
   input  logic                      wb_stb,
   input  logic                      wb_we,
   input  logic [`CONV_WB_ADR_W-1:0] wb_adr,
   input  logic [`CONV_WB_DAT_W-1:0] wb_dat_w,
   output logic [`CONV_WB_DAT_W-1:0] wb_dat_r,
   output logic                      wb_ack,

   // segment stream
   output logic                      seg_valid,
   input  logic                      seg_ready,
   output logic [`CONV_IDX_W-1:0]    seg_col_start,
   output logic [`CONV_IDX_W-1:0]    seg_col_end,
   output logic [`CONV_IDX_W-1:0]    seg_reg_start,
   output logic [`CONV_IDX_W-1:0]    seg_reg_end,
   output logic [`CONV_PARAM_W-1:0]  seg_west_pad,
   output logic [`CONV_PARAM_W-1:0]  seg_east_pad,

   output logic                      layer_done
);

   conv_geom_if geom ();

   logic         tile_go;
   logic         tile_end;
   idx_t         ox_start;
   logic         seg_load;
   logic         seg_taken;
   row_segment_t seg_next;
   row_segment_t seg_out;

   // end of layer goes back to the status register
   assign geom.layer_done = layer_done;

   conv_cfg_regs u_cfg_regs (
      .clk      (clk),
      .reset    (reset),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .geom     (geom.cfg)
   );

   conv_tile_sequencer u_tile_sequencer (
      .clk        (clk),
      .reset      (reset),
      .geom       (geom.user),
      .tile_end   (tile_end),
      .tile_go    (tile_go),
      .ox_start   (ox_start),
      .layer_done (layer_done)
   );

   conv_row_segment_gen u_row_segment_gen (
      .clk       (clk),
      .reset     (reset),
      .geom      (geom.user),
      .tile_go   (tile_go),
      .ox_start  (ox_start),
      .seg_taken (seg_taken),
      .seg_load  (seg_load),
      .seg       (seg_next),
      .tile_end  (tile_end)
   );

   conv_segment_issuer u_segment_issuer (
      .clk       (clk),
      .reset     (reset),
      .seg_load  (seg_load),
      .seg       (seg_next),
      .seg_ready (seg_ready),
      .seg_valid (seg_valid),
      .seg_out   (seg_out),
      .seg_taken (seg_taken)
   );

   // flatten the segment onto the pins
   assign seg_col_start = seg_out.col_start;
   assign seg_col_end   = seg_out.col_end;
   assign seg_reg_start = seg_out.reg_start;
   assign seg_reg_end   = seg_out.reg_end;
   assign seg_west_pad  = seg_out.west_pad;
   assign seg_east_pad  = seg_out.east_pad;

endmodule

//--- verif/conv_row_fetch_checker.sv
module conv_row_fetch_checker
   import conv_row_pkg::*;
(
   input logic         clk,
   input logic         reset,
   input logic         wb_ack,
   input logic         seg_valid,
   input logic         seg_ready,
   input row_segment_t seg
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0;

   // one ack cycle per access
   ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
      else begin
         $error("wb_ack stayed high for two cycles");
         fail_count++;
      end

   // stalled segment keeps its valid and fields
   seg_hold: assert property (@(posedge clk) disable iff (reset)
      (seg_valid && !seg_ready) |=> (seg_valid && $stable(seg)))
      else begin
         $error("segment changed or dropped while seg_ready was low");
         fail_count++;
      end

   valid_after_reset: assert property (@(posedge clk) reset |=> !seg_valid)
      else begin
         $error("seg_valid high right after reset");
         fail_count++;
      end

endmodule

bind conv_segment_issuer conv_row_fetch_checker u_seg_checker (
   .clk       (clk),
   .reset     (reset),
   .wb_ack    (1'b0),
   .seg_valid (seg_valid),
   .seg_ready (seg_ready),
   .seg       (seg_out)
);

bind conv_cfg_regs conv_row_fetch_checker u_wb_checker (
   .clk       (clk),
   .reset     (reset),
   .wb_ack    (wb_ack),
   .seg_valid (1'b0),
   .seg_ready (1'b1),
   .seg       ('0)
);

//--- verif/conv_row_fetch_tb.sv
`include "conv_row_macros.svh"

module conv_row_fetch_tb
   import conv_row_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD      = 20;
   localparam int TEST_COUNT      = 5;
   localparam int CYCLES_PER_TEST = 2000;

   logic                      clk;
   logic                      reset;
   logic                      wb_cyc;
   logic                      wb_stb;
   logic                      wb_we;
   logic [`CONV_WB_ADR_W-1:0] wb_adr;
   logic [`CONV_WB_DAT_W-1:0] wb_dat_w;
   logic [`CONV_WB_DAT_W-1:0] wb_dat_r;
   logic                      wb_ack;
   logic                      seg_valid;
   logic                      seg_ready;
   idx_t                      seg_col_start;
   idx_t                      seg_col_end;
   idx_t                      seg_reg_start;
   idx_t                      seg_reg_end;
   param_t                    seg_west_pad;
   param_t                    seg_east_pad;
   logic                      layer_done;

   // expected segments of the running layer
   row_segment_t exp_q[$];

   conv_row_fetch_top u_dut (
      .clk           (clk),
      .reset         (reset),
      .wb_cyc        (wb_cyc),
      .wb_stb        (wb_stb),
      .wb_we         (wb_we),
      .wb_adr        (wb_adr),
      .wb_dat_w      (wb_dat_w),
      .wb_dat_r      (wb_dat_r),
      .wb_ack        (wb_ack),
      .seg_valid     (seg_valid),
      .seg_ready     (seg_ready),
      .seg_col_start (seg_col_start),
      .seg_col_end   (seg_col_end),
      .seg_reg_start (seg_reg_start),
      .seg_reg_end   (seg_reg_end),
      .seg_west_pad  (seg_west_pad),
      .seg_east_pad  (seg_east_pad),
      .layer_done    (layer_done)
   );

   initial begin
      clk = 1'b0;
   end
   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // error handling and compares
   ////////////////////////////////////////////////////////////////////////////
   task automatic error_stop(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_seg(input string name, input row_segment_t got,
                            input row_segment_t exp);
      string msg;
      if (got !== exp) begin
         msg = $sformatf("[FAIL] %0t %s got col %0d..%0d reg %0d..%0d pad %0d/%0d",
                         $time, name, got.col_start, got.col_end, got.reg_start,
                         got.reg_end, got.west_pad, got.east_pad);
         msg = {msg, $sformatf(" exp col %0d..%0d reg %0d..%0d pad %0d/%0d",
                               exp.col_start, exp.col_end, exp.reg_start,
                               exp.reg_end, exp.west_pad, exp.east_pad)};
         error_stop(msg);
      end
   endtask

   task automatic check_word(input string name, input idx_t got, input idx_t exp);
      if (got !== exp) begin
         error_stop($sformatf("[FAIL] %0t %s got 0x%0h exp 0x%0h", $time, name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         error_stop($sformatf("[FAIL] %0t %s got %b exp %b", $time, name, got, exp));
      end
   endtask

   // any bound assertion failure ends the run
   always @(negedge clk) begin
      if ((u_dut.u_segment_issuer.u_seg_checker.fail_count != 0) ||
          (u_dut.u_cfg_regs.u_wb_checker.fail_count != 0)) begin
         error_stop("a bound handshake assertion failed");
      end
   end

   initial begin
      #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
      error_stop("watchdog expired before the tests finished");
   end

   ////////////////////////////////////////////////////////////////////////////
   // wishbone access
   ////////////////////////////////////////////////////////////////////////////
   task automatic wb_write(input cfg_addr_e adr, input logic [`CONV_WB_DAT_W-1:0] data);
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= 1'b1;
      wb_adr   <= adr;
      wb_dat_w <= data;
      do @(negedge clk); while (!wb_ack);
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic wb_read(input cfg_addr_e adr, output logic [`CONV_WB_DAT_W-1:0] data);
      @(posedge clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we  <= 1'b0;
      wb_adr <= adr;
      do @(negedge clk); while (!wb_ack);
      data = wb_dat_r;
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // reference model of the segment list
   ////////////////////////////////////////////////////////////////////////////

   // last image column of a phase at the end of its 32 pixel line inside the row
   function automatic int line_last(input int end_col, input int ix, input int p);
      int unp;
      unp = end_col - p - 1;
      if (unp < 0) begin
         unp = 0;
      end
      unp = (unp / `CONV_LINE_PIXELS) * `CONV_LINE_PIXELS + `CONV_LINE_PIXELS - 1;
      return (unp > ix - 1) ? ix - 1 : unp;
   endfunction

   task automatic build_model(input int ix, input int pox, input int k, input int s,
                              input int p);
      int           ox;
      int           ix_start;
      int           ix_end;
      int           ix_end_min;
      int           west;
      int           east;
      int           col;
      int           reg_next;
      int           seg_last;
      int           lim;
      int           phase_end[2];
      bit           first_seg;
      bit           fin;
      row_segment_t e;
      exp_q.delete();
      ox = (ix + 2 * p - k) / s + 1;
      for (int ox_start = 1; ox_start <= ox; ox_start += pox) begin
         ix_start   = (ox_start - 1) * s + 1;
         ix_end     = ix_start + (pox - 1) * s + k - 1;
         ix_end_min = ix_start + (pox - 1) * s + 1;
         if (ix_end_min > ix_end) begin
            ix_end_min = ix_end;
         end
         west = (ix_start <= p) ? p - ix_start + 1 : 0;
         east = (ix_end > p + ix) ? ix_end - p - ix : 0;
         col  = (ix_start - p - 1 > 0) ? ix_start - p - 1 : 0;
         phase_end[0] = line_last(ix_end_min, ix, p);
         phase_end[1] = line_last(ix_end, ix, p);
         reg_next  = west + 1;
         first_seg = 1'b1;
         // primary phase and then the tail up to the full kernel reach
         for (int ph = 0; ph < 2; ph++) begin
            lim = phase_end[ph];
            while (col <= lim) begin
               seg_last    = (col + `CONV_LINE_PIXELS - 1 < lim) ?
                             col + `CONV_LINE_PIXELS - 1 : lim;
               fin         = (seg_last == phase_end[1]);
               e.col_start = idx_t'(col);
               e.col_end   = idx_t'(seg_last);
               e.reg_start = idx_t'(reg_next);
               e.reg_end   = idx_t'(reg_next + seg_last - col + (fin ? east : 0));
               e.west_pad  = first_seg ? param_t'(west) : '0;
               e.east_pad  = fin ? param_t'(east) : '0;
               exp_q.push_back(e);
               reg_next  = reg_next + seg_last - col + 1;
               col       = seg_last + 1;
               first_seg = 1'b0;
            end
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // layer run and directed tests
   ////////////////////////////////////////////////////////////////////////////
   task automatic run_layer(input int ix, input int pox, input int k, input int s,
                            input int p, input bit random_ready);
      row_segment_t              got;
      int                        got_count;
      int                        done_count;
      logic [`CONV_WB_DAT_W-1:0] status;
      build_model(ix, pox, k, s, p);
      @(posedge clk);
      seg_ready <= 1'b0;
      wb_write(REG_IX, ix);
      wb_write(REG_POX, pox);
      wb_write(REG_KSP, (k << `CONV_KSP_K_LSB) | (s << `CONV_KSP_S_LSB) |
                        (p << `CONV_KSP_P_LSB));
      wb_write(REG_CTRL, 32'd1);
      // busy set and done cleared by the start
      wb_read(REG_STATUS, status);
      check_word("STATUS", idx_t'(status), idx_t'(1));
      got_count  = 0;
      done_count = 0;
      while (done_count == 0) begin
         @(posedge clk);
         seg_ready <= random_ready ? (($urandom % 3) != 0) : 1'b1;
         @(negedge clk);
         if (seg_valid && seg_ready) begin
            got.col_start = seg_col_start;
            got.col_end   = seg_col_end;
            got.reg_start = seg_reg_start;
            got.reg_end   = seg_reg_end;
            got.west_pad  = seg_west_pad;
            got.east_pad  = seg_east_pad;
            if (got_count >= exp_q.size()) begin
               error_stop("segment accepted beyond the expected list");
            end else begin
               check_seg("segment", got, exp_q[got_count]);
               got_count++;
            end
         end
         if (layer_done) begin
            done_count++;
            if (got_count != exp_q.size()) begin
               error_stop($sformatf("layer_done after %0d of %0d segments",
                                    got_count, exp_q.size()));
            end
         end
      end
      // nothing more may follow the end of the layer
      repeat (8) begin
         @(negedge clk);
         check_bit("seg_valid", seg_valid, 1'b0);
         check_bit("layer_done", layer_done, 1'b0);
      end
      wb_read(REG_STATUS, status);
      check_word("STATUS", idx_t'(status), idx_t'(2));
   endtask

   task automatic register_readback();
      logic [`CONV_WB_DAT_W-1:0] data;
      check_bit("wb_ack", wb_ack, 1'b0);
      check_bit("seg_valid", seg_valid, 1'b0);
      check_bit("layer_done", layer_done, 1'b0);
      wb_read(REG_STATUS, data);
      check_word("STATUS", idx_t'(data), idx_t'(0));
      wb_write(REG_IX, 32'd77);
      wb_read(REG_IX, data);
      check_word("IX", idx_t'(data), idx_t'(77));
      wb_write(REG_POX, 32'd12);
      wb_read(REG_POX, data);
      check_word("POX", idx_t'(data), idx_t'(12));
      wb_write(REG_KSP, 32'h215);
      wb_read(REG_KSP, data);
      check_word("KSP", idx_t'(data), idx_t'('h215));
   endtask

   task automatic restart_with_new_geometry();
      logic [`CONV_WB_DAT_W-1:0] data;
      wb_read(REG_STATUS, data);
      check_word("STATUS", idx_t'(data), idx_t'(2));
      run_layer(40, 10, 3, 1, 0, 1'b0);
   endtask

   initial begin
      void'($urandom(99));
      reset     = 1'b1;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = '0;
      wb_dat_w  = '0;
      seg_ready = 1'b0;
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);

      register_readback();
      // stride 1 with west and east pad
      run_layer(64, 16, 3, 1, 1, 1'b0);
      // stride 2 with tiles that have a tail phase
      run_layer(100, 8, 5, 2, 2, 1'b0);
      run_layer(100, 8, 5, 2, 2, 1'b1);
      restart_with_new_geometry();

      $display("Simulation passed");
      $finish;
   end

endmodule

//--- files.f
+incdir+verilog
verilog/conv_row_pkg.sv
verilog/conv_geom_if.sv
verilog/conv_cfg_regs.sv
verilog/conv_tile_sequencer.sv
verilog/conv_row_segment_gen.sv
verilog/conv_segment_issuer.sv
verilog/conv_row_fetch_top.sv
verif/conv_row_fetch_checker.sv
verif/conv_row_fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the row fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
   --top-module conv_row_fetch_tb -f files.f \
   -Mdir obj_dir -o conv_row_fetch_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/conv_row_fetch_sim +verilator+error+limit+100 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "Simulation passed"; then
   exit 0
else
   echo "pass message not found in simulation output"
   exit 1
fi
